// File: hw/icache_pkg.sv
// icache package: widths, address field helpers, port structs and controller states
`default_nettype none

package icache_pkg;

  localparam int unsigned addr_w   = 32;
  localparam int unsigned data_w   = 64;
  localparam int unsigned line_w   = 128;  // two fetch words
  localparam int unsigned tag_w    = 22;
  localparam int unsigned offset_w = 4;

  typedef struct packed {
    logic [addr_w-1:0] addr;  // fetch address
  } icache_req_t;

  typedef struct packed {
    logic [data_w-1:0] data;
  } icache_resp_t;

  typedef struct packed {
    logic [addr_w-1:0] addr;  // line aligned
    logic              len;   // 1 means two beats
  } mem_ar_t;

  typedef struct packed {
    logic [data_w-1:0] data;
    logic              last;
  } mem_r_t;

  typedef enum logic [2:0] {
    s_idle,
    s_lookup,
    s_ar,
    s_r,
    s_resp
  } ctrl_state_e;

  // set index, right aligned; caller keeps the low idx_w bits
  function automatic logic [addr_w-1:0] addr_index(logic [addr_w-1:0] addr,
                                                   int unsigned idx_w = addr_w - tag_w - offset_w);
    addr_index = (addr >> offset_w) & ((addr_w'(1) << idx_w) - addr_w'(1));
  endfunction

  // tag field, right aligned
  function automatic logic [addr_w-1:0] addr_tag(logic [addr_w-1:0] addr,
                                                 int unsigned idx_w = addr_w - tag_w - offset_w);
    addr_tag = addr >> (idx_w + offset_w);
  endfunction

  function automatic logic [addr_w-1:0] line_base(logic [addr_w-1:0] addr);
    line_base = {addr[addr_w-1:offset_w], {offset_w{1'b0}}};
  endfunction

  // bit 3 picks the upper word of the line
  function automatic logic word_upper(logic [addr_w-1:0] addr);
    word_upper = addr[offset_w-1];
  endfunction

endpackage

`default_nettype wire

// File: hw/icache_tag_store.sv
// icache tag store that keeps tag and valid bits per way and set and detects hits
`timescale 1ns/1ps
`default_nettype none

module icache_tag_store #(
  parameter int unsigned index_w = 6
) (
  input  logic                                                      clk,
  input  logic                                                      rst,
  input  icache_pkg::icache_req_t                                   lookup_addr_i,
  output logic                                                      hit_o,
  output logic                                                      hit_way_o,
  input  logic                                                      upd_en_i,
  input  logic [index_w-1:0]                                        upd_set_i,
  input  logic                                                      upd_way_i,
  input  logic [icache_pkg::addr_w-index_w-icache_pkg::offset_w-1:0] upd_tag_i,
  input  logic                                                      upd_valid_i
);
  import icache_pkg::*;

  localparam int unsigned sets     = 2 ** index_w;
  localparam int unsigned tag_bits = addr_w - index_w - offset_w;

  logic [tag_bits-1:0]     tag0_q [sets];
  logic [tag_bits-1:0]     tag1_q [sets];
  logic [1:0][sets-1:0]    valid_q;  // [way][set]

  logic [addr_w-1:0]       idx_full;
  logic [addr_w-1:0]       tag_full;
  logic [index_w-1:0]      look_idx;
  logic [tag_bits-1:0]     look_tag;
  logic [1:0]              match;

  // decode the lookup address
  assign idx_full = addr_index(lookup_addr_i.addr, index_w);
  assign tag_full = addr_tag(lookup_addr_i.addr, index_w);
  assign look_idx = idx_full[index_w-1:0];
  assign look_tag = tag_full[tag_bits-1:0];

  // compare both ways in parallel
  assign match[0] = valid_q[0][look_idx] && (tag0_q[look_idx] == look_tag);
  assign match[1] = valid_q[1][look_idx] && (tag1_q[look_idx] == look_tag);

  assign hit_o     = |match;
  assign hit_way_o = match[1];  // ways never share a valid tag

  // valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (upd_en_i) begin
      valid_q[upd_way_i][upd_set_i] <= upd_valid_i;
    end
  end

  // tag arrays written on refill
  always_ff @(posedge clk) begin
    if (upd_en_i) begin
      if (upd_way_i) begin
        tag1_q[upd_set_i] <= upd_tag_i;
      end else begin
        tag0_q[upd_set_i] <= upd_tag_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/icache_data_ram.sv
// icache data array for one way: 128-bit lines, synchronous read, half-line write
`timescale 1ns/1ps
`default_nettype none

module icache_data_ram #(
  parameter int unsigned index_w = 6
) (
  input  logic                          clk,
  input  logic [index_w-1:0]            addr_i,
  input  logic                          we_i,
  input  logic                          upper_i,
  input  logic [icache_pkg::data_w-1:0] wdata_i,
  output logic [icache_pkg::line_w-1:0] rdata_o
);
  import icache_pkg::*;

  localparam int unsigned sets = 2 ** index_w;

  // behavioural model of the single-port macro
  logic [line_w-1:0] mem_q [sets];
  logic [line_w-1:0] rdata_q;

  // one half of the line per write
  always_ff @(posedge clk) begin
    if (we_i) begin
      if (upper_i) begin
        mem_q[addr_i][line_w-1:data_w] <= wdata_i;
      end else begin
        mem_q[addr_i][data_w-1:0] <= wdata_i;
      end
    end
  end

  // registered read, old data on a same-cycle write
  always_ff @(posedge clk) begin
    rdata_q <= mem_q[addr_i];
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: hw/icache_refill_ctrl.sv
// icache controller: lookup and miss FSM, burst refill, victim choice and response register
`timescale 1ns/1ps
`default_nettype none

module icache_refill_ctrl #(
  parameter int unsigned index_w = 6
) (
  input  logic                                                      clk,
  input  logic                                                      rst,
  // fetch request and response
  input  logic                                                      req_valid_i,
  input  icache_pkg::icache_req_t                                   req_i,
  output logic                                                      req_ready_o,
  output logic                                                      resp_valid_o,
  output icache_pkg::icache_resp_t                                  resp_o,
  input  logic                                                      resp_ready_i,
  // memory read port
  output logic                                                      mem_ar_valid_o,
  output icache_pkg::mem_ar_t                                       mem_ar_o,
  input  logic                                                      mem_ar_ready_i,
  input  logic                                                      mem_r_valid_i,
  input  icache_pkg::mem_r_t                                        mem_r_i,
  output logic                                                      mem_r_ready_o,
  // tag store
  input  logic                                                      hit_i,
  input  logic                                                      hit_way_i,
  output icache_pkg::icache_req_t                                   lookup_addr_o,
  output logic                                                      upd_en_o,
  output logic [index_w-1:0]                                        upd_set_o,
  output logic                                                      upd_way_o,
  output logic [icache_pkg::addr_w-index_w-icache_pkg::offset_w-1:0] upd_tag_o,
  output logic                                                      upd_valid_o,
  // data arrays
  output logic [index_w-1:0]                                        ram_addr_o,
  output logic [1:0]                                                ram_we_o,
  output logic                                                      ram_upper_o,
  output logic [icache_pkg::data_w-1:0]                             ram_wdata_o,
  input  logic [icache_pkg::line_w-1:0]                             ram_rdata0_i,
  input  logic [icache_pkg::line_w-1:0]                             ram_rdata1_i
);
  import icache_pkg::*;

  localparam int unsigned tag_bits = addr_w - index_w - offset_w;

  ctrl_state_e         state_q;
  ctrl_state_e         state_d;
  icache_req_t         addr_q;    // accepted fetch
  logic                way_q;     // hit way or victim
  logic                victim_q;  // free-running toggle
  logic                beat_q;    // 0 lower word, 1 upper word
  logic [data_w-1:0]   resp_q;

  logic [addr_w-1:0]   cur_idx_full;
  logic [addr_w-1:0]   cur_tag_full;
  logic [line_w-1:0]   hit_line;
  logic                req_fire;
  logic                ar_fire;
  logic                r_fire;
  logic                miss_accept;

  assign req_fire    = req_valid_i & req_ready_o;
  assign ar_fire     = mem_ar_valid_o & mem_ar_ready_i;
  assign r_fire      = mem_r_valid_i & mem_r_ready_o;
  assign miss_accept = req_fire & ~hit_i;

  // incoming address while idle, held address otherwise
  assign lookup_addr_o = (state_q == s_idle) ? req_i : addr_q;
  assign cur_idx_full  = addr_index(lookup_addr_o.addr, index_w);
  assign cur_tag_full  = addr_tag(lookup_addr_o.addr, index_w);

  // tag update: invalidate victim on miss accept, validate on last beat
  assign upd_en_o    = miss_accept | (r_fire & mem_r_i.last);
  assign upd_set_o   = cur_idx_full[index_w-1:0];
  assign upd_way_o   = (state_q == s_idle) ? victim_q : way_q;
  assign upd_tag_o   = cur_tag_full[tag_bits-1:0];
  assign upd_valid_o = (state_q == s_r);

  // data arrays read at acceptance, written per refill beat
  assign ram_addr_o  = cur_idx_full[index_w-1:0];
  assign ram_we_o[0] = r_fire & ~way_q;
  assign ram_we_o[1] = r_fire & way_q;
  assign ram_upper_o = beat_q;
  assign ram_wdata_o = mem_r_i.data;

  assign hit_line = way_q ? ram_rdata1_i : ram_rdata0_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      s_idle:   if (req_fire) state_d = hit_i ? s_lookup : s_ar;
      s_lookup: state_d = s_resp;  // line arrives this cycle
      s_ar:     if (ar_fire) state_d = s_r;
      s_r:      if (r_fire && mem_r_i.last) state_d = s_resp;
      s_resp:   if (resp_ready_i) state_d = s_idle;
      default:  state_d = s_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= s_idle;
      victim_q <= 1'b0;
      beat_q   <= 1'b0;
    end else begin
      state_q  <= state_d;
      victim_q <= ~victim_q;
      if (r_fire) begin
        beat_q <= ~mem_r_i.last;  // back to 0 after the burst
      end
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (req_fire) begin
      addr_q <= req_i;
      way_q  <= hit_i ? hit_way_i : victim_q;
    end
    if (state_q == s_lookup) begin
      resp_q <= word_upper(addr_q.addr) ? hit_line[line_w-1:data_w] : hit_line[data_w-1:0];
    end else if (r_fire && (beat_q == word_upper(addr_q.addr))) begin
      resp_q <= mem_r_i.data;  // requested beat
    end
  end

  assign req_ready_o    = (state_q == s_idle);
  assign resp_valid_o   = (state_q == s_resp);
  assign resp_o.data    = resp_q;

  assign mem_ar_valid_o = (state_q == s_ar);
  assign mem_ar_o.addr  = line_base(addr_q.addr);
  assign mem_ar_o.len   = 1'b1;  // two beats
  assign mem_r_ready_o  = (state_q == s_r);

endmodule

`default_nettype wire

// File: hw/icache_top.sv
// icache top level: tag store, two way data arrays and refill controller
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
  parameter int unsigned index_w = 6
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req_valid_i,
  input  icache_pkg::icache_req_t  req_i,
  output logic                     req_ready_o,
  output logic                     resp_valid_o,
  output icache_pkg::icache_resp_t resp_o,
  input  logic                     resp_ready_i,
  output logic                     mem_ar_valid_o,
  output icache_pkg::mem_ar_t      mem_ar_o,
  input  logic                     mem_ar_ready_i,
  input  logic                     mem_r_valid_i,
  input  icache_pkg::mem_r_t       mem_r_i,
  output logic                     mem_r_ready_o
);
  import icache_pkg::*;

  icache_req_t                              lookup_addr;
  logic                                     hit;
  logic                                     hit_way;
  logic                                     upd_en;
  logic [index_w-1:0]                       upd_set;
  logic                                     upd_way;
  logic [addr_w-index_w-offset_w-1:0]       upd_tag;
  logic                                     upd_valid;
  logic [index_w-1:0]                       ram_addr;
  logic [1:0]                               ram_we;
  logic                                     ram_upper;
  logic [data_w-1:0]                        ram_wdata;
  logic [line_w-1:0]                        ram_rdata0;
  logic [line_w-1:0]                        ram_rdata1;

  icache_tag_store #(.index_w(index_w)) u_tag_store (
    .clk(clk), .rst(rst), .lookup_addr_i(lookup_addr),
    .hit_o(hit), .hit_way_o(hit_way),
    .upd_en_i(upd_en), .upd_set_i(upd_set), .upd_way_i(upd_way),
    .upd_tag_i(upd_tag), .upd_valid_i(upd_valid)
  );

  icache_data_ram #(.index_w(index_w)) u_way0 (
    .clk(clk), .addr_i(ram_addr), .we_i(ram_we[0]), .upper_i(ram_upper),
    .wdata_i(ram_wdata), .rdata_o(ram_rdata0)
  );

  icache_data_ram #(.index_w(index_w)) u_way1 (
    .clk(clk), .addr_i(ram_addr), .we_i(ram_we[1]), .upper_i(ram_upper),
    .wdata_i(ram_wdata), .rdata_o(ram_rdata1)
  );

  icache_refill_ctrl #(.index_w(index_w)) u_ctrl (
    .clk(clk), .rst(rst),
    .req_valid_i(req_valid_i), .req_i(req_i), .req_ready_o(req_ready_o),
    .resp_valid_o(resp_valid_o), .resp_o(resp_o), .resp_ready_i(resp_ready_i),
    .mem_ar_valid_o(mem_ar_valid_o), .mem_ar_o(mem_ar_o), .mem_ar_ready_i(mem_ar_ready_i),
    .mem_r_valid_i(mem_r_valid_i), .mem_r_i(mem_r_i), .mem_r_ready_o(mem_r_ready_o),
    .hit_i(hit), .hit_way_i(hit_way), .lookup_addr_o(lookup_addr),
    .upd_en_o(upd_en), .upd_set_o(upd_set), .upd_way_o(upd_way),
    .upd_tag_o(upd_tag), .upd_valid_o(upd_valid),
    .ram_addr_o(ram_addr), .ram_we_o(ram_we), .ram_upper_o(ram_upper),
    .ram_wdata_o(ram_wdata), .ram_rdata0_i(ram_rdata0), .ram_rdata1_i(ram_rdata1)
  );

endmodule

`default_nettype wire

// File: verif/icache_mem_model.sv
// icache testbench memory: answers two-beat line bursts with address-derived data and stalls
`timescale 1ns/1ps
`default_nettype none

module icache_mem_model #(
  parameter logic [31:0] seed = 32'h4e69_0b44
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                ar_valid_i,
  input  icache_pkg::mem_ar_t ar_i,
  output logic                ar_ready_o,
  output logic                r_valid_o,
  output icache_pkg::mem_r_t  r_o,
  input  logic                r_ready_i
);
  import icache_pkg::*;

  logic [31:0]       rng;
  logic              busy;
  logic              beat;      // 0 lower word, 1 upper word
  logic [addr_w-1:0] base_q;
  logic              ar_fire_q;
  logic              r_fire_q;

  function automatic logic [31:0] xorshift(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // fixed mix of the beat address with a constant
  function automatic logic [data_w-1:0] beat_word(logic [addr_w-1:0] a);
    return {a ^ 32'h5bd1_e995, {a[15:0], a[31:16]} + 32'h9e37_79b9};
  endfunction

  initial begin
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_o        = '0;
    rng        = seed;
  end

  // handshakes as seen at the rising edge
  always @(posedge clk) begin
    ar_fire_q <= ar_valid_i & ar_ready_o;
    r_fire_q  <= r_valid_o & r_ready_i;
    if (ar_valid_i && ar_ready_o) begin
      base_q <= ar_i.addr;
    end
  end

  // outputs move on the falling edge
  always @(negedge clk) begin
    rng = xorshift(rng);
    if (rst) begin
      busy = 1'b0;
      beat = 1'b0;
    end else if (ar_fire_q) begin
      busy = 1'b1;
      beat = 1'b0;
    end else if (r_fire_q) begin
      busy = ~beat;  // idle after the last beat
      beat = ~beat;
    end
    ar_ready_o = ~busy & ~rst & (rng[1:0] != 2'b00);
    r_valid_o  = busy & (rng[3:2] != 2'b00);
    r_o.data   = beat_word(base_q + {28'h0, beat, 3'b000});
    r_o.last   = beat;
  end

endmodule

`default_nettype wire

// File: verif/icache_tb.sv
// icache testbench: fetch stimulus with stalls, reference check of responses and bursts
`timescale 1ns/1ps
`default_nettype none

module icache_tb;
  import icache_pkg::*;

  localparam int unsigned index_w     = 6;
  localparam int unsigned n_fetches   = 96;
  localparam int unsigned miss_bound  = 60;  // cycles per fetch, stalls included
  localparam int unsigned cycle_limit = n_fetches * miss_bound + 20;
  localparam logic [31:0] seed        = 32'h4e69_0b44;

  logic         clk;
  logic         rst;
  logic         req_valid;
  icache_req_t  req;
  logic         req_ready;
  logic         resp_valid;
  icache_resp_t resp;
  logic         resp_ready;
  logic         ar_valid;
  mem_ar_t      ar;
  logic         ar_ready;
  logic         r_valid;
  mem_r_t       r;
  logic         r_ready;

  logic [31:0]  stim_rng;
  logic [31:0]  ready_rng;
  int           ready_hold = 0;
  int           cycle = 0;
  int           accept_cycle = 0;
  int           resp_count = 0;
  int           burst_count = 0;
  logic [31:0]  cur_addr = '0;
  logic [27:0]  prev_line = '0;
  logic         have_prev = 1'b0;
  logic         expect_hit = 1'b0;  // same line as the fetch before
  logic         burst_seen = 1'b0;
  logic         first_seen = 1'b0;
  logic         in_flight = 1'b0;
  logic         held = 1'b0;
  icache_resp_t held_resp;
  logic [27:0]  seen_lines [$];

  icache_top #(.index_w(index_w)) dut (
    .clk(clk), .rst(rst),
    .req_valid_i(req_valid), .req_i(req), .req_ready_o(req_ready),
    .resp_valid_o(resp_valid), .resp_o(resp), .resp_ready_i(resp_ready),
    .mem_ar_valid_o(ar_valid), .mem_ar_o(ar), .mem_ar_ready_i(ar_ready),
    .mem_r_valid_i(r_valid), .mem_r_i(r), .mem_r_ready_o(r_ready)
  );

  icache_mem_model #(.seed(seed)) u_mem (
    .clk(clk), .rst(rst), .ar_valid_i(ar_valid), .ar_i(ar), .ar_ready_o(ar_ready),
    .r_valid_o(r_valid), .r_o(r), .r_ready_i(r_ready)
  );

  function automatic logic [31:0] xorshift(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // expected word of the 8-byte block holding the fetch address
  function automatic logic [data_w-1:0] ref_word(logic [addr_w-1:0] addr);
    logic [31:0] a;
    a = {addr[31:3], 3'b000};
    return {a ^ 32'h5bd1_e995, {a[15:0], a[31:16]} + 32'h9e37_79b9};
  endfunction

  function automatic logic line_seen(logic [27:0] line);
    for (int k = 0; k < seen_lines.size(); k++) begin
      if (seen_lines[k] == line) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) report_failure($sformatf("Error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_resp(input string name, input icache_resp_t got, input icache_resp_t exp);
    if (got !== exp) begin
      report_failure($sformatf("Error: %s got %h expected %h", name, got.data, exp.data));
    end
  endtask

  task automatic check_ar(input string name, input mem_ar_t got, input mem_ar_t exp);
    if (got !== exp) begin
      report_failure($sformatf("Error: %s got addr %h len %h expected addr %h len %h",
                               name, got.addr, got.len, exp.addr, exp.len));
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // compare process, samples at the rising edge
  always @(posedge clk) begin
    icache_resp_t exp_resp;
    mem_ar_t      exp_ar;
    cycle++;
    if (cycle > cycle_limit) report_failure("Timeout: the fetch sequence did not complete");
    if (!rst) begin
      if (in_flight) check_flag("req_ready_o", req_ready, 1'b0);  // one fetch at a time
      if (held) begin
        check_flag("resp_valid_o", resp_valid, 1'b1);
        check_resp("resp_o", resp, held_resp);
      end
      if (ar_valid && ar_ready) begin
        exp_ar.addr = {cur_addr[31:4], 4'h0};
        exp_ar.len  = 1'b1;
        check_ar("mem_ar_o", ar, exp_ar);
        if (expect_hit) report_failure("A burst was issued for the line just filled");
        burst_seen = 1'b1;
        burst_count++;
      end
      if (resp_valid && !first_seen) begin
        first_seen = 1'b1;
        if (expect_hit && (cycle - accept_cycle) != 2) begin
          report_failure($sformatf("Error: resp_valid_o latency got %h expected %h",
                                   cycle - accept_cycle, 2));
        end
      end
      held      = resp_valid & ~resp_ready;
      held_resp = resp;
      if (resp_valid && resp_ready) begin
        exp_resp.data = ref_word(cur_addr);
        check_resp("resp_o", resp, exp_resp);
        if (!line_seen(cur_addr[31:4]) && !burst_seen) begin
          report_failure("The first fetch of a line issued no burst");
        end
        seen_lines.push_back(cur_addr[31:4]);
        in_flight = 1'b0;
        resp_count++;
      end
      if (req_valid && req_ready) begin
        cur_addr     = req.addr;
        expect_hit   = have_prev && (req.addr[31:4] == prev_line);
        prev_line    = req.addr[31:4];
        have_prev    = 1'b1;
        burst_seen   = 1'b0;
        first_seen   = 1'b0;
        accept_cycle = cycle;
        in_flight    = 1'b1;
      end
    end
  end

  // random stretches of response back-pressure
  always @(negedge clk) begin
    if (ready_hold == 0) begin
      ready_rng  = xorshift(ready_rng);
      resp_ready = ready_rng[0];
      ready_hold = ready_rng[3:1];
    end else begin
      ready_hold--;
    end
  end

  initial begin
    logic [31:0] addr;
    logic [31:0] pick;
    logic [31:0] prev;
    rst        = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    resp_ready = 1'b0;
    stim_rng   = seed;
    ready_rng  = xorshift(seed ^ 32'h0000_ffff);
    prev       = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_flag("req_ready_o", req_ready, 1'b1);
    check_flag("resp_valid_o", resp_valid, 1'b0);
    check_flag("mem_ar_valid_o", ar_valid, 1'b0);
    check_flag("mem_r_ready_o", r_ready, 1'b0);
    for (int i = 0; i < n_fetches; i++) begin
      stim_rng = xorshift(stim_rng);
      pick     = stim_rng;
      stim_rng = xorshift(stim_rng);
      case (i)
        0:       addr = 32'h0000_1000;
        1:       addr = 32'h0000_1008;  // upper word, same line
        2:       addr = 32'h0040_1000;  // same set, other tag
        3:       addr = 32'h0000_100c;
        default: begin
          case (pick[1:0])
            2'd0:       addr = {prev[31:4], stim_rng[3:0]};
            2'd1, 2'd2: addr = {18'h0, stim_rng[13:0]};  // small region, reuse
            default:    addr = stim_rng;
          endcase
        end
      endcase
      req_valid = 1'b1;
      req.addr  = addr;
      while (!req_ready) @(negedge clk);
      @(negedge clk);  // taken on the edge in between
      req_valid = 1'b0;
      if (pick[2]) @(negedge clk);
      prev = addr;
    end
    while (resp_count < n_fetches) @(negedge clk);
    repeat (4) @(negedge clk);
    if (resp_count == n_fetches && burst_count > 0 && !in_flight) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      report_failure("The run ended with missing responses or without any burst");
    end
  end

endmodule

`default_nettype wire

// File: project.f
hw/icache_pkg.sv
hw/icache_tag_store.sv
hw/icache_data_ram.sv
hw/icache_refill_ctrl.sv
hw/icache_top.sv
verif/icache_mem_model.sv
verif/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - files:
      - hw/icache_pkg.sv
      - hw/icache_tag_store.sv
      - hw/icache_data_ram.sv
      - hw/icache_refill_ctrl.sv
      - hw/icache_top.sv
  - target: test
    files:
      - verif/icache_mem_model.sv
      - verif/icache_tb.sv
